//--- list.f
+incdir+hdl
hdl/mgmt_pkg.sv
hdl/mgmt_reg_decoder.sv
hdl/mdio_transceiver.sv
hdl/mgmt_readback.sv
hdl/mgmt_subsystem.sv
tests/mdio_phy_model.sv
tests/mgmt_subsystem_tb.sv

//--- tests/mgmt_stimulus.txt
# kind ch phy reg data expected, all hex
# regw/regr: reg is the full byte address; fill: data is the PHY memory base
fill 0 0 00 a5c3 0
regr 0 0 00 0 00
regr 0 0 07 0 00
regr 0 0 17 0 00
regr 0 0 40 0 00
regr 0 0 41 0 00
regw 0 0 09 1f 0
regr 0 0 09 0 1f
regw 0 0 12 5a 0
regr 0 0 12 0 5a
regw 0 0 40 07 0
regr 0 0 40 0 07
regr 0 0 30 0 00
regr 0 0 55 0 00
regw 0 0 40 00 0
mdw 0 1 03 beef 0
mdr 0 1 03 0 beef
mdw 2 4 1f 1234 0
mdr 2 4 1f 0 1234
mdr 1 2 05 0 a4c6
mdr 0 1 09 0 a5ca
mdx 1 2 03 5678 0
irq 0 0 00 00 0
irq 0 0 00 02 1
regr 0 0 0f 0 02
regr 0 0 0f 0 00
irq 0 0 00 02 0
busy 0 1 04 0 a5c7
pst 0 1 02 0 0
pst 1 2 03 0 0
pst 2 4 06 0 0
pwt 0 0 00 0 a5c1
pwt 1 0 00 0 5678
pwt 2 0 00 0 a7c5

//--- tests/mgmt_subsystem_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "mgmt_config.svh"

module mgmt_subsystem_tb import mgmt_pkg::*; ();

	localparam int NCH     = `MGMT_NUM_CHANNELS;
	localparam int TIMEOUT = 2000;

	logic           sys_clk;
	logic           arst_n;
	mgmt_wr_t       wr;
	mgmt_rd_t       rd;
	wire            rd_valid;
	wire [7:0]      rd_data;
	wire            irq;
	wire [NCH-1:0]  mdc;
	wire [NCH-1:0]  mdio_out;
	wire [NCH-1:0]  mdio_oe;
	wire [NCH-1:0]  mdio_in;
	wire [NCH-1:0]  drive_err;
	logic [15:0]    fill_base;
	logic           fill;

	mgmt_subsystem i_mgmt_subsystem (
		.sys_clk  (sys_clk),
		.arst_n   (arst_n),
		.wr       (wr),
		.rd       (rd),
		.rd_valid (rd_valid),
		.rd_data  (rd_data),
		.irq      (irq),
		.mdc      (mdc),
		.mdio_out (mdio_out),
		.mdio_oe  (mdio_oe),
		.mdio_in  (mdio_in)
	);

	// One PHY per channel, at the address the stimulus uses for that channel
	for (genvar c = 0; c < NCH; c++) begin : g_phy
		mdio_phy_model #(
			.CH       (c),
			.PHY_ADDR (5'(1 << c))
		) i_phy (
			.arst_n    (arst_n),
			.mdc       (mdc[c]),
			.mdio_out  (mdio_out[c]),
			.mdio_oe   (mdio_oe[c]),
			.fill_base (fill_base),
			.fill      (fill),
			.mdio_in   (mdio_in[c]),
			.drive_err (drive_err[c])
		);
	end

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Failure, bus access and compares

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic next_cycle();
		@(posedge sys_clk);
		#1;
	endtask

	task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
		wr = '{en: 1'b1, addr: addr, data: data};
		next_cycle();
		wr.en = 1'b0;
	endtask

	// rd_valid must already be high one cycle after the strobe
	task automatic bus_read(input logic [7:0] addr, input string name,
			output logic [7:0] data);
		int cnt;
		cnt = 0;
		rd = '{en: 1'b1, addr: addr};
		next_cycle();
		rd.en = 1'b0;
		while (!rd_valid) begin
			if (cnt == TIMEOUT)
				stop_run($sformatf("%s: rd_valid never came for address %h", name, addr));
			next_cycle();
			cnt++;
		end
		if (cnt != 0)
			stop_run($sformatf("%s: rd_valid came %0d cycles late", name, cnt));
		data = rd_data;
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp_v,
			input logic [7:0] act_v);
		if (act_v !== exp_v)
			stop_run($sformatf("FAIL %s expected %h actual %h", name, exp_v, act_v));
	endtask

	// Read data assembled from the low and high bytes
	task automatic check_word(input string name, input int ch, input logic [15:0] exp_v);
		logic [7:0] lo;
		logic [7:0] hi;
		bus_read(8'(ch * `REG_CH_STRIDE) + `REG_RD_LO, name, lo);
		bus_read(8'(ch * `REG_CH_STRIDE) + `REG_RD_HI, name, hi);
		if ({hi, lo} !== exp_v)
			stop_run($sformatf("FAIL %s expected %h actual %h", name, exp_v, {hi, lo}));
	endtask

	task automatic check_irq(input string name, input logic exp_v);
		if (irq !== exp_v)
			stop_run($sformatf("FAIL %s expected %b actual %b", name, exp_v, irq));
	endtask

	// MDIO pins as mdc, oe, out groups
	task automatic check_pins(input string name, input logic [NCH-1:0] exp_mdc,
			input logic [NCH-1:0] exp_oe, input logic [NCH-1:0] exp_out);
		if ({mdc, mdio_oe, mdio_out} !== {exp_mdc, exp_oe, exp_out})
			stop_run($sformatf("FAIL %s expected %b actual %b", name,
				{exp_mdc, exp_oe, exp_out}, {mdc, mdio_oe, mdio_out}));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// MDIO command helpers

	task automatic start_op(input int ch, input logic [7:0] phy, input logic [7:0] rg,
			input logic [15:0] data, input logic is_rd);
		logic [7:0] base;
		base = 8'(ch * `REG_CH_STRIDE);
		bus_write(base + `REG_MD_ADDR, phy);
		bus_write(base + `REG_REG_ADDR, rg);
		if (!is_rd) begin
			bus_write(base + `REG_WR_LO, data[7:0]);
			bus_write(base + `REG_WR_HI, data[15:8]);
		end
		bus_write(base + `REG_CMD, is_rd ? 8'd2 : 8'd1);
	endtask

	// Pending register does not clear, so poll it
	task automatic wait_pending(input int ch, input string name);
		logic [7:0] v;
		int         cnt;
		cnt = 0;
		v   = '0;
		while (!v[ch]) begin
			if (cnt == TIMEOUT)
				stop_run($sformatf("%s: channel %0d never completed", name, ch));
			bus_read(`REG_IRQ_PEND, name, v);
			cnt++;
		end
	endtask

	// Status shows done once, idle, then clears
	task automatic wait_done(input int ch, input string name);
		logic [7:0] v;
		wait_pending(ch, name);
		bus_read(8'(ch * `REG_CH_STRIDE) + `REG_STATUS, name, v);
		check_byte(name, 8'h02, v);
		if (drive_err[ch])
			stop_run($sformatf("%s: channel %0d kept driving MDIO after the read turnaround",
				name, ch));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus file driver

	initial begin
		int          fd;
		int          n;
		int          lineno;
		int          ch;
		string       line;
		string       kind;
		string       name;
		logic [7:0]  phy;
		logic [7:0]  rg;
		logic [15:0] data;
		logic [15:0] exp_v;
		logic [7:0]  v;

		wr        = '0;
		rd        = '0;
		fill_base = '0;
		fill      = 1'b0;
		arst_n    = 1'b0;
		lineno    = 0;
		void'($urandom(59373));
		repeat (2) @(posedge sys_clk);
		#1;
		arst_n = 1'b1;
		next_cycle();

		// Idle line after reset
		check_pins("reset pins", '0, '0, '1);

		fd = $fopen("tests/mgmt_stimulus.txt", "r");
		if (fd == 0)
			stop_run("cannot open tests/mgmt_stimulus.txt");

		while (!$feof(fd)) begin
			line = "";
			n    = $fgets(line, fd);
			lineno++;
			if (n == 0 || line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%s %h %h %h %h %h", kind, ch, phy, rg, data, exp_v);
			if (n != 6)
				stop_run($sformatf("malformed stimulus line %0d", lineno));
			name = $sformatf("%s line %0d", kind, lineno);

			case (kind)
				"fill": begin
					fill_base = data;
					fill      = 1'b1;
					next_cycle();
					fill      = 1'b0;
				end
				// Register ops take a full byte address in the reg column
				"regw": bus_write(rg, data[7:0]);
				"regr": begin
					bus_read(rg, name, v);
					check_byte(name, exp_v[7:0], v);
				end
				"mdw": begin
					start_op(ch, phy, rg, data, 1'b0);
					wait_done(ch, name);
				end
				"mdr": begin
					start_op(ch, phy, rg, data, 1'b1);
					wait_done(ch, name);
					check_word(name, ch, exp_v);
				end
				// Write left pending for the irq checks
				"mdx": begin
					start_op(ch, phy, rg, data, 1'b0);
					wait_pending(ch, name);
				end
				"irq": begin
					bus_write(`REG_IRQ_MASK, data[7:0]);
					next_cycle();
					check_irq(name, exp_v[0]);
				end
				// Second read of another register while busy is dropped
				"busy": begin
					start_op(ch, phy, rg, data, 1'b1);
					start_op(ch, phy, rg + 8'd1, data, 1'b1);
					wait_done(ch, name);
					check_word(name, ch, exp_v);
				end
				"pst": start_op(ch, phy, rg, data, 1'b1);
				"pwt": begin
					wait_done(ch, name);
					check_word(name, ch, exp_v);
				end
				default: stop_run($sformatf("unknown stimulus kind on line %0d", lineno));
			endcase

			// Random idle gap
			repeat ($urandom % 4) next_cycle();
		end
		$fclose(fd);

		// All channels back to idle
		check_pins("idle pins", '0, '0, '1);

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/mdio_phy_model.sv
`timescale 1ns/10ps
`default_nettype none

module mdio_phy_model #(
	parameter int         CH       = 0,
	// Clause-22 address this PHY answers
	parameter logic [4:0] PHY_ADDR = 5'd0
) (
	input wire         arst_n,
	input wire         mdc,
	input wire         mdio_out,
	input wire         mdio_oe,
	// Memory fill from the stimulus header
	input wire [15:0]  fill_base,
	input wire         fill,
	output logic       mdio_in,
	// Master kept driving after the read turnaround
	output wire        drive_err
);

	logic [15:0] mem [32];
	logic [12:0] hdr;
	logic [15:0] wdata;
	logic        active = 1'b0;
	logic        oe_late = 1'b0;
	logic        rd_op;
	logic        hit;
	logic [4:0]  ra;
	int          ones;
	int          idx;
	wire         line_val = mdio_oe ? mdio_out : 1'b1;

	assign drive_err = oe_late;

	// Pattern covers channel and the whole register address
	always @(posedge fill) begin
		for (int r = 0; r < 32; r++)
			mem[r] = fill_base ^ {8'(CH), 3'b000, 5'(r)};
	end

	////////////////////////////////////////////////////////////////////////////
	// Frame receiver, sampled on rising MDC

	always @(posedge mdc or negedge arst_n) begin
		if (!arst_n) begin
			active  = 1'b0;
			oe_late = 1'b0;
			ones    = 0;
			idx     = 0;
			rd_op   = 1'b0;
			hit     = 1'b0;
		end else if (!active) begin
			// Preamble, then the 0 of ST opens the frame
			if (line_val)
				ones++;
			else if (ones >= 32) begin
				active = 1'b1;
				idx    = 1;
				hdr    = '0;
			end else
				ones = 0;
		end else begin
			// ST low bit, OP, PHYAD, REGAD
			if (idx < 14)
				hdr = {hdr[11:0], line_val};
			if (idx == 13) begin
				rd_op = (hdr[11:10] == 2'b10);
				hit   = (hdr[9:5] == PHY_ADDR);
				ra    = hdr[4:0];
			end
			// Line belongs to the PHY from the first TA bit of a read
			if (idx >= 14 && rd_op && mdio_oe)
				oe_late = 1'b1;
			if (idx >= 16 && !rd_op)
				wdata = {wdata[14:0], line_val};
			if (idx == 31) begin
				if (!rd_op && hit)
					mem[ra] = wdata;
				active = 1'b0;
				ones   = 0;
			end
			idx++;
		end
	end

	// Read data changes on falling MDC, MSB first
	always @(negedge mdc or negedge arst_n) begin
		if (!arst_n)
			mdio_in = 1'b1;
		else if (active && rd_op && hit && idx >= 16 && idx <= 31)
			mdio_in = mem[ra][31-idx];
		else
			mdio_in = 1'b1;
	end

endmodule

`default_nettype wire

//--- hdl/mgmt_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

`include "mgmt_config.svh"

module mgmt_subsystem import mgmt_pkg::*; (
	input wire                               sys_clk,
	input wire                               arst_n,

	// Host register bus
	input wire mgmt_wr_t                     wr,
	input wire mgmt_rd_t                     rd,
	output logic                             rd_valid,
	output logic [7:0]                       rd_data,
	output logic                             irq,

	// MDIO pins, one per channel
	output logic [`MGMT_NUM_CHANNELS-1:0]    mdc,
	output logic [`MGMT_NUM_CHANNELS-1:0]    mdio_out,
	output logic [`MGMT_NUM_CHANNELS-1:0]    mdio_oe,
	input wire [`MGMT_NUM_CHANNELS-1:0]      mdio_in
);

	mdio_cmd_t [`MGMT_NUM_CHANNELS-1:0]    cmd;
	mdio_req_t [`MGMT_NUM_CHANNELS-1:0]    req;
	mdio_result_t [`MGMT_NUM_CHANNELS-1:0] res;
	logic [`MGMT_NUM_CHANNELS-1:0]         irq_mask;

	////////////////////////////////////////////////////////////////////////////
	// Host writes to commands

	mgmt_reg_decoder i_mgmt_reg_decoder (
		.sys_clk  (sys_clk),
		.arst_n   (arst_n),
		.wr       (wr),
		.cmd      (cmd),
		.req      (req),
		.irq_mask (irq_mask)
	);

	////////////////////////////////////////////////////////////////////////////
	// MDIO masters

	for (genvar c = 0; c < `MGMT_NUM_CHANNELS; c++) begin : g_chan
		mdio_transceiver i_mdio_transceiver (
			.sys_clk  (sys_clk),
			.arst_n   (arst_n),
			.cmd      (cmd[c]),
			.req      (req[c]),
			.res      (res[c]),
			.mdc      (mdc[c]),
			.mdio_out (mdio_out[c]),
			.mdio_oe  (mdio_oe[c]),
			.mdio_in  (mdio_in[c])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// Host reads and interrupt

	mgmt_readback i_mgmt_readback (
		.sys_clk  (sys_clk),
		.arst_n   (arst_n),
		.rd       (rd),
		.cmd      (cmd),
		.irq_mask (irq_mask),
		.res      (res),
		.rd_valid (rd_valid),
		.rd_data  (rd_data),
		.irq      (irq)
	);

endmodule

`default_nettype wire

//--- hdl/mgmt_readback.sv
`timescale 1ns/10ps
`default_nettype none

`include "mgmt_config.svh"

module mgmt_readback import mgmt_pkg::*; (
	input wire                                     sys_clk,
	input wire                                     arst_n,

	// Host read port
	input wire mgmt_rd_t                           rd,

	// Sources for readback
	input wire mdio_cmd_t [`MGMT_NUM_CHANNELS-1:0]    cmd,
	input wire [`MGMT_NUM_CHANNELS-1:0]               irq_mask,
	input wire mdio_result_t [`MGMT_NUM_CHANNELS-1:0] res,

	output logic                                   rd_valid,
	output logic [7:0]                             rd_data,
	output logic                                   irq
);

	localparam logic [7:0] CH_STRIDE = 8'(`REG_CH_STRIDE);

	logic [`MGMT_NUM_CHANNELS-1:0] done_flags;
	logic [`MGMT_NUM_CHANNELS-1:0] done_pulse;
	logic [`MGMT_NUM_CHANNELS-1:0] status_rd;
	logic [7:0]                    rd_ch;
	logic [7:0]                    rd_off;
	logic [7:0]                    rd_mux;

	assign rd_ch  = rd.addr / CH_STRIDE;
	assign rd_off = rd.addr % CH_STRIDE;

	////////////////////////////////////////////////////////////////////////////
	// Read mux

	always_comb begin
		rd_mux    = '0;
		status_rd = '0;
		for (int c = 0; c < `MGMT_NUM_CHANNELS; c++) begin
			done_pulse[c] = res[c].done;
			if (rd_ch == 8'(c)) begin
				case (rd_off)
					`REG_MD_ADDR:  rd_mux = {3'b000, cmd[c].phy_addr};
					`REG_REG_ADDR: rd_mux = {3'b000, cmd[c].reg_addr};
					`REG_WR_LO:    rd_mux = cmd[c].wr_data[7:0];
					`REG_WR_HI:    rd_mux = cmd[c].wr_data[15:8];
					`REG_RD_LO:    rd_mux = res[c].rd_data[7:0];
					`REG_RD_HI:    rd_mux = res[c].rd_data[15:8];
					`REG_STATUS: begin
						// Flags as they stand before the clear
						rd_mux       = {6'b000000, done_flags[c], res[c].busy};
						status_rd[c] = rd.en;
					end
					// Command register is write-only
					default: rd_mux = '0;
				endcase
			end
		end

		if (rd.addr == `REG_IRQ_MASK)
			rd_mux = 8'(irq_mask);
		else if (rd.addr == `REG_IRQ_PEND)
			rd_mux = 8'(done_flags);
	end

	////////////////////////////////////////////////////////////////////////////
	// Sticky flags and read pipeline

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			done_flags <= '0;
			rd_valid   <= 1'b0;
			rd_data    <= '0;
		end else begin
			// A new done pulse beats the clear from a status read
			done_flags <= done_pulse | (done_flags & ~status_rd);
			rd_valid   <= rd.en;
			if (rd.en)
				rd_data <= rd_mux;
		end
	end

	// Pending under mask
	assign irq = |(done_flags & irq_mask);

endmodule

`default_nettype wire

//--- hdl/mdio_transceiver.sv
`timescale 1ns/10ps
`default_nettype none

`include "mgmt_config.svh"

module mdio_transceiver import mgmt_pkg::*; (
	input wire               sys_clk,
	input wire               arst_n,

	// Command side
	input wire mdio_cmd_t    cmd,
	input wire mdio_req_t    req,
	output mdio_result_t     res,

	// MDIO pins, no pad buffer here
	output logic             mdc,
	output logic             mdio_out,
	output logic             mdio_oe,
	input wire               mdio_in
);

	////////////////////////////////////////////////////////////////////////////
	// Clock divider and bit timing

	localparam int DIV_W = $clog2(`MDIO_CLK_DIV + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`MDIO_CLK_DIV - 1);

	logic             busy;
	logic             done_q;
	logic             is_read;
	logic [DIV_W-1:0] div_cnt;
	logic [5:0]       bit_cnt;
	logic [5:0]       bit_next;
	logic             accept;
	logic             tick;
	logic             rise;
	logic             fall;
	mdio_frame_u      frame;
	logic [15:0]      rd_shift;
	logic [15:0]      rd_data_q;

	// Starts while busy are dropped
	assign accept = req.start && !busy;

	// MDC toggles each half period
	assign tick = busy && (div_cnt == DIV_LAST);
	assign rise = tick && !mdc;
	assign fall = tick && mdc;

	// Bit times 0..31 preamble, 32..63 frame
	assign bit_next = bit_cnt + 6'd1;

	////////////////////////////////////////////////////////////////////////////
	// Control FSM

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			busy      <= 1'b0;
			done_q    <= 1'b0;
			is_read   <= 1'b0;
			div_cnt   <= '0;
			bit_cnt   <= '0;
			mdc       <= 1'b0;
			mdio_oe   <= 1'b0;
			mdio_out  <= 1'b1;
			rd_data_q <= '0;
		end else begin
			done_q <= 1'b0;
			if (accept) begin
				// First preamble bit driven right away
				busy     <= 1'b1;
				is_read  <= req.is_read;
				div_cnt  <= '0;
				bit_cnt  <= '0;
				mdc      <= 1'b0;
				mdio_oe  <= 1'b1;
				mdio_out <= 1'b1;
			end else if (busy) begin
				if (tick) begin
					div_cnt <= '0;
					mdc     <= ~mdc;
				end else begin
					div_cnt <= div_cnt + 1'b1;
				end

				// New bits go out after falling MDC
				if (fall) begin
					if (bit_cnt == 6'd63) begin
						busy     <= 1'b0;
						done_q   <= 1'b1;
						mdio_oe  <= 1'b0;
						mdio_out <= 1'b1;
						if (is_read)
							rd_data_q <= rd_shift;
					end else begin
						bit_cnt <= bit_next;
						// Frame MSB first, raw[30] is the next bit before the shift
						if (bit_next == 6'd32)
							mdio_out <= frame.raw[31];
						else if (bit_next > 6'd32)
							mdio_out <= frame.raw[30];
						// Release the line at the first TA bit of a read
						if (is_read && (bit_next == 6'd46))
							mdio_oe <= 1'b0;
					end
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Frame and read shift registers

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			frame.f.st       <= 2'b01;
			frame.f.op       <= req.is_read ? 2'b10 : 2'b01;
			frame.f.phy_addr <= cmd.phy_addr;
			frame.f.reg_addr <= cmd.reg_addr;
			frame.f.ta       <= req.is_read ? 2'b11 : 2'b10;
			frame.f.data     <= req.is_read ? 16'h0000 : cmd.wr_data;
		end else if (fall && (bit_next > 6'd32)) begin
			frame.raw <= {frame.raw[30:0], 1'b0};
		end

		// PHY data sampled on rising MDC
		if (rise && is_read && (bit_cnt >= 6'd48))
			rd_shift <= {rd_shift[14:0], mdio_in};
	end

	assign res = '{busy: busy, done: done_q, rd_data: rd_data_q};

	////////////////////////////////////////////////////////////////////////////
	// Checks

	// Busy only ever follows a start from the decoder
	a_busy_needs_start: assert property (
		@(posedge sys_clk) disable iff (!arst_n)
		$rose(busy) |-> $past(req.start)
	);

	// Line is never driven between frames
	a_idle_oe_low: assert property (
		@(posedge sys_clk) disable iff (!arst_n)
		!busy |-> !mdio_oe
	);

endmodule

`default_nettype wire

//--- hdl/mgmt_reg_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "mgmt_config.svh"

module mgmt_reg_decoder import mgmt_pkg::*; (
	input wire                                    sys_clk,
	input wire                                    arst_n,

	// Host write port
	input wire mgmt_wr_t                          wr,

	// Per-channel command and start
	output mdio_cmd_t [`MGMT_NUM_CHANNELS-1:0]    cmd,
	output mdio_req_t [`MGMT_NUM_CHANNELS-1:0]    req,

	// Interrupt enable, one bit per channel
	output logic [`MGMT_NUM_CHANNELS-1:0]         irq_mask
);

	////////////////////////////////////////////////////////////////////////////
	// Address split

	localparam logic [7:0] CH_STRIDE = 8'(`REG_CH_STRIDE);

	logic [7:0]                    wr_ch;
	logic [7:0]                    wr_off;
	logic                          cmd_ok;
	logic [`MGMT_NUM_CHANNELS-1:0] start_vec;

	// Channel block index and byte within it
	assign wr_ch  = wr.addr / CH_STRIDE;
	assign wr_off = wr.addr % CH_STRIDE;

	// Only 1 (write) and 2 (read) are commands
	assign cmd_ok = (wr.data == 8'd1) || (wr.data == 8'd2);

	////////////////////////////////////////////////////////////////////////////
	// Register file

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			cmd      <= '0;
			req      <= '0;
			irq_mask <= '0;
		end else begin
			for (int c = 0; c < `MGMT_NUM_CHANNELS; c++) begin
				// Start is a single registered pulse
				req[c].start <= wr.en && (wr_ch == 8'(c)) && (wr_off == `REG_CMD) && cmd_ok;

				if (wr.en && (wr_ch == 8'(c))) begin
					case (wr_off)
						`REG_MD_ADDR:  cmd[c].phy_addr      <= wr.data[4:0];
						`REG_REG_ADDR: cmd[c].reg_addr      <= wr.data[4:0];
						`REG_WR_LO:    cmd[c].wr_data[7:0]  <= wr.data;
						`REG_WR_HI:    cmd[c].wr_data[15:8] <= wr.data;
						`REG_CMD: begin
							// Kind follows the start, ignored values leave it alone
							if (cmd_ok)
								req[c].is_read <= (wr.data == 8'd2);
						end
						default: ;
					endcase
				end
			end

			// Global mask register
			if (wr.en && (wr.addr == `REG_IRQ_MASK))
				irq_mask <= wr.data[`MGMT_NUM_CHANNELS-1:0];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks

	always_comb begin
		for (int c = 0; c < `MGMT_NUM_CHANNELS; c++)
			start_vec[c] = req[c].start;
	end

	// One host write addresses one channel only
	a_single_start: assert property (
		@(posedge sys_clk) disable iff (!arst_n)
		$onehot0(start_vec)
	);

endmodule

`default_nettype wire

//--- hdl/mgmt_pkg.sv
`default_nettype none

package mgmt_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Host register bus

	// Write strobe, taken on the edge where en is high
	typedef struct packed {
		logic       en;
		logic [7:0] addr;
		logic [7:0] data;
	} mgmt_wr_t;

	// Read strobe, data comes back one cycle later
	typedef struct packed {
		logic       en;
		logic [7:0] addr;
	} mgmt_rd_t;

	////////////////////////////////////////////////////////////////////////////
	// MDIO command path

	// Configuration level held by the decoder
	typedef struct packed {
		logic [4:0]  phy_addr;
		logic [4:0]  reg_addr;
		logic [15:0] wr_data;
	} mdio_cmd_t;

	// One-cycle start with the operation kind
	typedef struct packed {
		logic start;
		logic is_read;
	} mdio_req_t;

	// Status back to the readback collector
	typedef struct packed {
		logic        busy;
		logic        done;
		logic [15:0] rd_data;
	} mdio_result_t;

	// Clause-22 frame fields after the preamble, MSB goes out first
	typedef struct packed {
		logic [1:0]  st;
		logic [1:0]  op;
		logic [4:0]  phy_addr;
		logic [4:0]  reg_addr;
		logic [1:0]  ta;
		logic [15:0] data;
	} mdio_frame_fields_t;

	// Loaded by field, shifted as a raw word
	typedef union packed {
		logic [31:0]        raw;
		mdio_frame_fields_t f;
	} mdio_frame_u;

endpackage

`default_nettype wire

//--- hdl/mgmt_config.svh
`ifndef MGMT_CONFIG_SVH
`define MGMT_CONFIG_SVH

// Number of MDIO masters, one per PHY group
`define MGMT_NUM_CHANNELS 3

// sys_clk cycles per MDC half period
// Small value keeps simulation short
`define MDIO_CLK_DIV 4

// Byte stride between per-channel register blocks
`define REG_CH_STRIDE 8

// Per-channel register offsets
`define REG_MD_ADDR  8'd0
`define REG_REG_ADDR 8'd1
`define REG_WR_LO    8'd2
`define REG_WR_HI    8'd3
`define REG_CMD      8'd4
`define REG_RD_LO    8'd5
`define REG_RD_HI    8'd6
`define REG_STATUS   8'd7

// Global registers above the channel blocks
`define REG_IRQ_MASK 8'h40
`define REG_IRQ_PEND 8'h41

`endif
